/* rtl/dual_mips_pkg.sv */
package dual_mips_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam logic [xlen-1:0] reset_pc = 32'hbfc0_0000;

    // primary opcodes
    localparam logic [5:0] opc_special = 6'h00;
    localparam logic [5:0] opc_beq = 6'h04;
    localparam logic [5:0] opc_bne = 6'h05;
    localparam logic [5:0] opc_addiu = 6'h09;
    localparam logic [5:0] opc_ori = 6'h0d;
    localparam logic [5:0] opc_lui = 6'h0f;

    // funct codes under special
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2a;

    typedef enum logic [3:0] {
        op_none,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_slt,
        op_lui,
        op_beq,
        op_bne
    } op_e;

    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [reg_addr_w-1:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0] opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [15:0] imm;
        } i;
    } instr_u;

endpackage

/* rtl/fetch.sv */
module fetch import dual_mips_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic stall_f,
    input  logic stall_f2,
    input  logic flush_f2,
    input  logic branch_taken,
    input  logic [xlen-1:0] branch_target,
    output logic ireq_valid,
    output logic [xlen-1:0] ireq_addr,
    input  logic [63:0] iresp_data,
    output logic [1:0] slot_valid,
    output logic [1:0][xlen-1:0] slot_pc,
    output instr_u slot_instr [1:0]
);
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_succ;
    logic [xlen-1:0] saved_target;
    logic [xlen-1:0] f2_pc;
    logic target_saved;
    logic f2_valid;
    logic pair_held;
    logic [63:0] held_pair;
    logic [63:0] pair;

    // no request while the pc is about to be redirected
    assign ireq_valid = !branch_taken && !target_saved;
    assign ireq_addr = pc;
    assign pc_succ = pc[2] ? pc + 32'd4 : pc + 32'd8;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (!stall_f) begin
            if (branch_taken) begin
                pc <= branch_target;
            end else if (target_saved) begin
                pc <= saved_target;
            end else begin
                pc <= pc_succ;
            end
        end
    end

    // redirect that arrives during a stall waits here
    always_ff @(posedge clk) begin
        if (reset) begin
            target_saved <= 1'b0;
        end else if (stall_f && branch_taken) begin
            target_saved <= 1'b1;
        end else if (!stall_f) begin
            target_saved <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (stall_f && branch_taken) begin
            saved_target <= branch_target;
        end
    end

    // f2 only advances on an accepted request
    always_ff @(posedge clk) begin
        if (reset || flush_f2) begin
            f2_valid <= 1'b0;
        end else if (!stall_f2) begin
            f2_valid <= ireq_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_f2) begin
            f2_pc <= pc;
        end
    end

    // bus data lasts one cycle, so keep it across the stall
    always_ff @(posedge clk) begin
        if (reset || flush_f2 || !stall_f2) begin
            pair_held <= 1'b0;
        end else if (f2_valid) begin
            pair_held <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (stall_f2 && !pair_held) begin
            held_pair <= iresp_data;
        end
    end

    assign pair = pair_held ? held_pair : iresp_data;

    // slot 1 is the older word
    assign slot_valid[1] = f2_valid && !stall_f2;
    assign slot_valid[0] = f2_valid && !stall_f2 && !f2_pc[2];
    assign slot_pc[1] = f2_pc;
    assign slot_pc[0] = f2_pc + 32'd4;
    assign slot_instr[1] = f2_pc[2] ? pair[63:32] : pair[31:0];
    assign slot_instr[0] = pair[63:32];

endmodule

/* rtl/decode.sv */
module decode import dual_mips_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic flush,
    input  logic [1:0] slot_valid,
    input  logic [1:0][xlen-1:0] slot_pc,
    input  instr_u slot_instr [1:0],
    output logic [1:0] d_valid,
    output logic [1:0][xlen-1:0] d_pc,
    output op_e d_op [1:0],
    output logic [1:0][reg_addr_w-1:0] d_rs,
    output logic [1:0][reg_addr_w-1:0] d_rt,
    output logic [1:0][reg_addr_w-1:0] d_rd,
    output logic [1:0][xlen-1:0] d_imm,
    output logic [1:0] d_use_imm,
    output logic [1:0] d_wen
);
    op_e nxt_op [1:0];
    logic [1:0][reg_addr_w-1:0] nxt_dst;
    logic [1:0][xlen-1:0] nxt_imm;
    logic [1:0] nxt_use_imm;
    logic [1:0] nxt_wen;

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            nxt_op[k] = op_none;
            nxt_dst[k] = slot_instr[k].i.rt;
            nxt_imm[k] = {{16{slot_instr[k].i.imm[15]}}, slot_instr[k].i.imm};
            nxt_use_imm[k] = 1'b1;
            case (slot_instr[k].r.opcode)
                opc_special: begin
                    nxt_dst[k] = slot_instr[k].r.rd;
                    nxt_use_imm[k] = 1'b0;
                    if (slot_instr[k].r.shamt == '0) begin
                        case (slot_instr[k].r.funct)
                            fn_addu: nxt_op[k] = op_add;
                            fn_subu: nxt_op[k] = op_sub;
                            fn_and: nxt_op[k] = op_and;
                            fn_or: nxt_op[k] = op_or;
                            fn_slt: nxt_op[k] = op_slt;
                            default: nxt_op[k] = op_none;
                        endcase
                    end
                end
                opc_addiu: nxt_op[k] = op_add;
                opc_ori: begin
                    nxt_op[k] = op_or;
                    nxt_imm[k] = {16'h0, slot_instr[k].i.imm};
                end
                opc_lui: begin
                    nxt_op[k] = op_lui;
                    nxt_imm[k] = {slot_instr[k].i.imm, 16'h0};
                end
                opc_beq, opc_bne: begin
                    nxt_op[k] = (slot_instr[k].i.opcode == opc_beq) ? op_beq : op_bne;
                    nxt_use_imm[k] = 1'b0;
                    // branch offset in bytes
                    nxt_imm[k] = {{14{slot_instr[k].i.imm[15]}}, slot_instr[k].i.imm, 2'b00};
                end
                default: nxt_op[k] = op_none;
            endcase
            // writes to r0 are dropped right here
            nxt_wen[k] = nxt_op[k] != op_none && nxt_op[k] != op_beq &&
                         nxt_op[k] != op_bne && nxt_dst[k] != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            d_valid <= '0;
        end else if (!stall) begin
            d_valid <= slot_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int k = 0; k < 2; k++) begin
                d_pc[k] <= slot_pc[k];
                d_op[k] <= nxt_op[k];
                d_rs[k] <= slot_instr[k].i.rs;
                d_rt[k] <= slot_instr[k].i.rt;
                d_rd[k] <= nxt_dst[k];
                d_imm[k] <= nxt_imm[k];
                d_use_imm[k] <= nxt_use_imm[k];
                d_wen[k] <= nxt_wen[k];
            end
        end
    end

endmodule

/* rtl/issue.sv */
module issue import dual_mips_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic [1:0] d_valid,
    input  logic [1:0][xlen-1:0] d_pc,
    input  op_e d_op [1:0],
    input  logic [1:0][reg_addr_w-1:0] d_rs,
    input  logic [1:0][reg_addr_w-1:0] d_rt,
    input  logic [1:0][reg_addr_w-1:0] d_rd,
    input  logic [1:0][xlen-1:0] d_imm,
    input  logic [1:0] d_use_imm,
    input  logic [1:0] d_wen,
    input  logic [1:0] e_wen,
    input  logic [1:0][reg_addr_w-1:0] e_wnum,
    input  logic [1:0][xlen-1:0] e_result,
    input  logic [1:0] r_wen,
    input  logic [1:0][reg_addr_w-1:0] r_wnum,
    input  logic [1:0][xlen-1:0] r_wdata,
    output logic [3:0][reg_addr_w-1:0] rf_ra,
    input  logic [3:0][xlen-1:0] rf_rd,
    output logic issue_hold,
    output logic [1:0] i_valid,
    output logic [1:0][xlen-1:0] i_pc,
    output op_e i_op [1:0],
    output logic [1:0][xlen-1:0] i_srca,
    output logic [1:0][xlen-1:0] i_srcb,
    output logic [1:0][xlen-1:0] i_imm,
    output logic [1:0] i_wen,
    output logic [1:0][reg_addr_w-1:0] i_wnum
);
    logic lo_valid;
    logic [xlen-1:0] lo_pc;
    op_e lo_op;
    logic [reg_addr_w-1:0] lo_rs;
    logic [reg_addr_w-1:0] lo_rt;
    logic [reg_addr_w-1:0] lo_wnum;
    logic [xlen-1:0] lo_imm;
    logic lo_use_imm;
    logic lo_wen;
    logic dep;
    logic split;
    logic [1:0] s_valid;
    logic [1:0][xlen-1:0] s_pc;
    op_e s_op [1:0];
    logic [1:0][reg_addr_w-1:0] s_rs;
    logic [1:0][reg_addr_w-1:0] s_rt;
    logic [1:0][reg_addr_w-1:0] s_wnum;
    logic [1:0][xlen-1:0] s_imm;
    logic [1:0] s_use_imm;
    logic [1:0] s_wen;
    logic [1:0][xlen-1:0] opa;
    logic [1:0][xlen-1:0] opb;

    // younger slot reading the older destination
    assign dep = d_wen[1] && (d_rs[0] == d_rd[1] || (!d_use_imm[0] && d_rt[0] == d_rd[1]));
    assign split = d_valid[1] && d_valid[0] &&
                   (dep || d_op[1] == op_beq || d_op[1] == op_bne);
    assign issue_hold = lo_valid;

    always_comb begin
        s_valid = {d_valid[1], d_valid[0] && !split};
        s_pc = d_pc;
        s_op = d_op;
        s_rs = d_rs;
        s_rt = d_rt;
        s_wnum = d_rd;
        s_imm = d_imm;
        s_use_imm = d_use_imm;
        s_wen = d_wen;
        if (lo_valid) begin
            // leftover goes out alone in the older slot
            s_valid = 2'b10;
            s_pc[1] = lo_pc;
            s_op[1] = lo_op;
            s_rs[1] = lo_rs;
            s_rt[1] = lo_rt;
            s_wnum[1] = lo_wnum;
            s_imm[1] = lo_imm;
            s_use_imm[1] = lo_use_imm;
            s_wen[1] = lo_wen;
        end
    end

    assign rf_ra = {s_rs[1], s_rt[1], s_rs[0], s_rt[0]};

    // later checks win, so younger e has the last word
    function automatic logic [xlen-1:0] fwd(input logic [reg_addr_w-1:0] n,
                                            input logic [xlen-1:0] rf_val);
        logic [xlen-1:0] v;
        v = rf_val;
        if (r_wen[1] && r_wnum[1] == n) v = r_wdata[1];
        if (r_wen[0] && r_wnum[0] == n) v = r_wdata[0];
        if (e_wen[1] && e_wnum[1] == n) v = e_result[1];
        if (e_wen[0] && e_wnum[0] == n) v = e_result[0];
        return v;
    endfunction

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            opa[k] = fwd(s_rs[k], rf_rd[2*k+1]);
            opb[k] = s_use_imm[k] ? s_imm[k] : fwd(s_rt[k], rf_rd[2*k]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            lo_valid <= 1'b0;
        end else begin
            lo_valid <= !lo_valid && split;
        end
    end

    always_ff @(posedge clk) begin
        if (!lo_valid) begin
            lo_pc <= d_pc[0];
            lo_op <= d_op[0];
            lo_rs <= d_rs[0];
            lo_rt <= d_rt[0];
            lo_wnum <= d_rd[0];
            lo_imm <= d_imm[0];
            lo_use_imm <= d_use_imm[0];
            lo_wen <= d_wen[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            i_valid <= '0;
        end else begin
            i_valid <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        i_pc <= s_pc;
        i_op <= s_op;
        i_srca <= opa;
        i_srcb <= opb;
        i_imm <= s_imm;
        i_wen <= s_wen;
        i_wnum <= s_wnum;
    end

endmodule

/* rtl/regfile.sv */
module regfile import dual_mips_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic [3:0][reg_addr_w-1:0] ra,
    output logic [3:0][xlen-1:0] rd,
    input  logic [1:0] wen,
    input  logic [1:0][reg_addr_w-1:0] wa,
    input  logic [1:0][xlen-1:0] wd
);
    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < 2**reg_addr_w; n++) begin
                regs[n] <= '0;
            end
        end else begin
            // older port first so the younger write lands last
            for (int k = 1; k >= 0; k--) begin
                if (wen[k] && wa[k] != '0) begin
                    regs[wa[k]] <= wd[k];
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rd[k] = (ra[k] == '0) ? '0 : regs[ra[k]];
        end
    end

endmodule

/* rtl/execute.sv */
module execute import dual_mips_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic [1:0] i_valid,
    input  logic [1:0][xlen-1:0] i_pc,
    input  op_e i_op [1:0],
    input  logic [1:0][xlen-1:0] i_srca,
    input  logic [1:0][xlen-1:0] i_srcb,
    input  logic [1:0][xlen-1:0] i_imm,
    input  logic [1:0] i_wen,
    input  logic [1:0][reg_addr_w-1:0] i_wnum,
    output logic [1:0] e_wen,
    output logic [1:0][reg_addr_w-1:0] e_wnum,
    output logic [1:0][xlen-1:0] e_result,
    output logic branch_taken,
    output logic [xlen-1:0] branch_target,
    output logic retire0_valid,
    output logic [xlen-1:0] retire0_pc,
    output logic retire0_wen,
    output logic [reg_addr_w-1:0] retire0_wnum,
    output logic [xlen-1:0] retire0_wdata,
    output logic retire1_valid,
    output logic [xlen-1:0] retire1_pc,
    output logic retire1_wen,
    output logic [reg_addr_w-1:0] retire1_wnum,
    output logic [xlen-1:0] retire1_wdata
);
    logic [1:0] take;
    logic [1:0][xlen-1:0] target;
    logic [1:0] ret_valid;
    logic [1:0] ret_wen;
    logic [1:0][xlen-1:0] ret_pc;
    logic [1:0][reg_addr_w-1:0] ret_wnum;
    logic [1:0][xlen-1:0] ret_wdata;

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            case (i_op[k])
                op_add: e_result[k] = i_srca[k] + i_srcb[k];
                op_sub: e_result[k] = i_srca[k] - i_srcb[k];
                op_and: e_result[k] = i_srca[k] & i_srcb[k];
                op_or: e_result[k] = i_srca[k] | i_srcb[k];
                op_slt: e_result[k] = {{(xlen-1){1'b0}},
                                       $signed(i_srca[k]) < $signed(i_srcb[k])};
                op_lui: e_result[k] = i_srcb[k];
                default: e_result[k] = '0;
            endcase
            take[k] = i_valid[k] && (i_op[k] == op_beq || i_op[k] == op_bne) &&
                      ((i_srca[k] == i_srcb[k]) != (i_op[k] == op_bne));
            target[k] = i_pc[k] + 32'd4 + i_imm[k];
        end
    end

    // a younger branch can only be paired behind an alu op
    assign branch_taken = |take;
    assign branch_target = take[1] ? target[1] : target[0];

    assign e_wnum = i_wnum;
    assign e_wen[1] = i_valid[1] && i_wen[1];
    assign e_wen[0] = i_valid[0] && i_wen[0] && !take[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            ret_valid <= '0;
            ret_wen <= '0;
        end else begin
            ret_valid <= {i_valid[1], i_valid[0] && !take[1]};
            ret_wen <= e_wen;
        end
    end

    always_ff @(posedge clk) begin
        ret_pc <= i_pc;
        ret_wnum <= i_wnum;
        ret_wdata <= e_result;
    end

    assign retire0_valid = ret_valid[1];
    assign retire0_pc = ret_pc[1];
    assign retire0_wen = ret_wen[1];
    assign retire0_wnum = ret_wnum[1];
    assign retire0_wdata = ret_wdata[1];
    assign retire1_valid = ret_valid[0];
    assign retire1_pc = ret_pc[0];
    assign retire1_wen = ret_wen[0];
    assign retire1_wnum = ret_wnum[0];
    assign retire1_wdata = ret_wdata[0];

endmodule

/* rtl/hazard.sv */
module hazard (
    input  logic ireq_valid,
    input  logic iresp_addr_ok,
    input  logic issue_hold,
    input  logic branch_taken,
    output logic stall_f,
    output logic stall_f2,
    output logic stall_d,
    output logic flush_f2,
    output logic flush_d,
    output logic flush_i
);
    logic bus_wait;

    assign bus_wait = ireq_valid && !iresp_addr_ok;

    assign stall_f = bus_wait || issue_hold;
    assign stall_f2 = bus_wait || issue_hold;
    // redirect wins over the leftover hold
    assign stall_d = issue_hold && !branch_taken;

    assign flush_f2 = branch_taken;
    assign flush_d = branch_taken;
    assign flush_i = branch_taken;

endmodule

/* rtl/dual_mips.sv */
module dual_mips import dual_mips_pkg::*; (
    input  logic clk,
    input  logic reset,
    output logic ireq_valid,
    output logic [xlen-1:0] ireq_addr,
    input  logic iresp_addr_ok,
    input  logic [63:0] iresp_data,
    output logic retire0_valid,
    output logic [xlen-1:0] retire0_pc,
    output logic retire0_wen,
    output logic [reg_addr_w-1:0] retire0_wnum,
    output logic [xlen-1:0] retire0_wdata,
    output logic retire1_valid,
    output logic [xlen-1:0] retire1_pc,
    output logic retire1_wen,
    output logic [reg_addr_w-1:0] retire1_wnum,
    output logic [xlen-1:0] retire1_wdata
);
    logic stall_f;
    logic stall_f2;
    logic stall_d;
    logic flush_f2;
    logic flush_d;
    logic flush_i;
    logic issue_hold;
    logic branch_taken;
    logic [xlen-1:0] branch_target;
    logic [1:0] slot_valid;
    logic [1:0][xlen-1:0] slot_pc;
    instr_u slot_instr [1:0];
    logic [1:0] d_valid;
    logic [1:0][xlen-1:0] d_pc;
    op_e d_op [1:0];
    logic [1:0][reg_addr_w-1:0] d_rs;
    logic [1:0][reg_addr_w-1:0] d_rt;
    logic [1:0][reg_addr_w-1:0] d_rd;
    logic [1:0][xlen-1:0] d_imm;
    logic [1:0] d_use_imm;
    logic [1:0] d_wen;
    logic [3:0][reg_addr_w-1:0] rf_ra;
    logic [3:0][xlen-1:0] rf_rd;
    logic [1:0] i_valid;
    logic [1:0][xlen-1:0] i_pc;
    op_e i_op [1:0];
    logic [1:0][xlen-1:0] i_srca;
    logic [1:0][xlen-1:0] i_srcb;
    logic [1:0][xlen-1:0] i_imm;
    logic [1:0] i_wen;
    logic [1:0][reg_addr_w-1:0] i_wnum;
    logic [1:0] e_wen;
    logic [1:0][reg_addr_w-1:0] e_wnum;
    logic [1:0][xlen-1:0] e_result;
    logic [1:0] r_wen;
    logic [1:0][reg_addr_w-1:0] r_wnum;
    logic [1:0][xlen-1:0] r_wdata;

    // index 1 is the older slot, which retires on port 0
    assign r_wen = {retire0_wen, retire1_wen};
    assign r_wnum = {retire0_wnum, retire1_wnum};
    assign r_wdata = {retire0_wdata, retire1_wdata};

    hazard hazard_inst (
        .ireq_valid, .iresp_addr_ok, .issue_hold, .branch_taken,
        .stall_f, .stall_f2, .stall_d, .flush_f2, .flush_d, .flush_i
    );

    fetch fetch_inst (
        .clk, .reset, .stall_f, .stall_f2, .flush_f2, .branch_taken, .branch_target,
        .ireq_valid, .ireq_addr, .iresp_data, .slot_valid, .slot_pc, .slot_instr
    );

    decode decode_inst (
        .clk, .reset, .stall(stall_d), .flush(flush_d),
        .slot_valid, .slot_pc, .slot_instr,
        .d_valid, .d_pc, .d_op, .d_rs, .d_rt, .d_rd, .d_imm, .d_use_imm, .d_wen
    );

    issue issue_inst (
        .clk, .reset, .flush(flush_i),
        .d_valid, .d_pc, .d_op, .d_rs, .d_rt, .d_rd, .d_imm, .d_use_imm, .d_wen,
        .e_wen, .e_wnum, .e_result, .r_wen, .r_wnum, .r_wdata,
        .rf_ra, .rf_rd, .issue_hold,
        .i_valid, .i_pc, .i_op, .i_srca, .i_srcb, .i_imm, .i_wen, .i_wnum
    );

    regfile regfile_inst (
        .clk, .reset, .ra(rf_ra), .rd(rf_rd), .wen(r_wen), .wa(r_wnum), .wd(r_wdata)
    );

    execute execute_inst (
        .clk, .reset,
        .i_valid, .i_pc, .i_op, .i_srca, .i_srcb, .i_imm, .i_wen, .i_wnum,
        .e_wen, .e_wnum, .e_result, .branch_taken, .branch_target,
        .retire0_valid, .retire0_pc, .retire0_wen, .retire0_wnum, .retire0_wdata,
        .retire1_valid, .retire1_pc, .retire1_wen, .retire1_wnum, .retire1_wdata
    );

endmodule

/* verif/dual_mips_chk.sv */
module dual_mips_chk (
    input logic clk,
    input logic reset,
    input logic [31:0] ireq_addr,
    input logic retire0_valid,
    input logic retire0_wen,
    input logic [4:0] retire0_wnum,
    input logic retire1_valid,
    input logic retire1_wen,
    input logic [4:0] retire1_wnum
);
    int fail_count = 0;

    a_retire_order: assert property (@(posedge clk) disable iff (reset)
        retire1_valid |-> retire0_valid)
        else begin
            $error("retire1_valid high without retire0_valid");
            fail_count++;
        end

    a_addr_aligned: assert property (@(posedge clk) disable iff (reset)
        ireq_addr[1:0] == 2'b00)
        else begin
            $error("ireq_addr not word aligned");
            fail_count++;
        end

    a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
        !(retire0_valid && retire0_wen && retire0_wnum == 5'd0) &&
        !(retire1_valid && retire1_wen && retire1_wnum == 5'd0))
        else begin
            $error("register 0 retired with wen high");
            fail_count++;
        end

    // first cycle out of reset
    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !retire0_valid && !retire1_valid)
        else begin
            $error("retire valid high right after reset");
            fail_count++;
        end

endmodule

bind dual_mips dual_mips_chk chk_inst (
    .clk(clk),
    .reset(reset),
    .ireq_addr(ireq_addr),
    .retire0_valid(retire0_valid),
    .retire0_wen(retire0_wen),
    .retire0_wnum(retire0_wnum),
    .retire1_valid(retire1_valid),
    .retire1_wen(retire1_wen),
    .retire1_wnum(retire1_wnum)
);

/* verif/retire_monitor.sv */
module retire_monitor (
    input logic clk,
    input logic reset,
    input logic retire0_valid,
    input logic [31:0] retire0_pc,
    input logic retire0_wen,
    input logic [4:0] retire0_wnum,
    input logic [31:0] retire0_wdata,
    input logic retire1_valid,
    input logic [31:0] retire1_pc,
    input logic retire1_wen,
    input logic [4:0] retire1_wnum,
    input logic [31:0] retire1_wdata,
    input logic [31:0] pat [0:127],
    input int list_base,
    input int exp_count,
    output int retired,
    output int mismatches,
    output int others,
    output int dual_retires
);
    initial begin
        retired = 0;
        mismatches = 0;
        others = 0;
        dual_retires = 0;
    end

    task automatic compare_write(input int port, input logic [31:0] pc,
                                 input logic [4:0] wnum, input logic [31:0] wdata);
        int idx;
        idx = list_base + 1 + 3 * retired;
        if (retired >= exp_count) begin
            $display("unexpected register write retired past the end of the list, pc %h",
                     pc);
            others++;
        end else begin
            if (pc !== pat[idx]) begin
                $display("[FAIL] retire%0d_pc entry %0d: got %h expected %h",
                         port, retired, pc, pat[idx]);
                mismatches++;
            end
            if (wnum !== pat[idx+1][4:0]) begin
                $display("[FAIL] retire%0d_wnum entry %0d: got %h expected %h",
                         port, retired, wnum, pat[idx+1][4:0]);
                mismatches++;
            end
            if (wdata !== pat[idx+2]) begin
                $display("[FAIL] retire%0d_wdata entry %0d: got %h expected %h",
                         port, retired, wdata, pat[idx+2]);
                mismatches++;
            end
        end
        retired++;
    endtask

    // port 0 holds the older instruction
    always @(posedge clk) begin
        if (!reset) begin
            // both ports busy in one cycle
            if (retire0_valid && retire1_valid) begin
                dual_retires++;
            end
            if (retire0_valid && retire0_wen) begin
                compare_write(0, retire0_pc, retire0_wnum, retire0_wdata);
            end
            if (retire1_valid && retire1_wen) begin
                compare_write(1, retire1_pc, retire1_wnum, retire1_wdata);
            end
        end
    end

endmodule

/* verif/tb_top.sv */
module clk_gen (
    output logic clk
);
    initial clk = 1'b0;
    always #4 clk = ~clk;
endmodule

module tb_top import dual_mips_pkg::*; ();
    logic clk;
    logic reset;
    logic ireq_valid;
    logic [31:0] ireq_addr;
    logic iresp_addr_ok;
    logic [63:0] iresp_data;
    logic retire0_valid;
    logic [31:0] retire0_pc;
    logic retire0_wen;
    logic [4:0] retire0_wnum;
    logic [31:0] retire0_wdata;
    logic retire1_valid;
    logic [31:0] retire1_pc;
    logic retire1_wen;
    logic [4:0] retire1_wnum;
    logic [31:0] retire1_wdata;
    logic [31:0] pat [0:127];
    logic [31:0] rng;
    int prog_len;
    int list_base;
    int exp_count;
    int retired;
    int mismatches;
    int others;
    int dual_retires;
    bit loaded;

    clk_gen clk_gen_inst (.clk(clk));

    dual_mips UUT (.*);

    retire_monitor monitor_inst (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // outside the program every word differs with its index
    function automatic logic [31:0] word_at(input logic [31:0] idx);
        if (idx < 32'(prog_len)) begin
            return pat[int'(idx) + 1];
        end
        return 32'hdead_0000 ^ idx;
    endfunction

    // aligned pair, lower address in the low half
    function automatic logic [63:0] fetch_pair(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - reset_pc) >> 2;
        idx[0] = 1'b0;
        return {word_at(idx + 32'd1), word_at(idx)};
    endfunction

    always @(posedge clk) begin
        logic accepted;
        logic [31:0] addr;
        accepted = ireq_valid && iresp_addr_ok;
        addr = ireq_addr;
        #1;
        if (accepted) begin
            iresp_data = fetch_pair(addr);
        end
        rng = lcg_next(rng);
        iresp_addr_ok = rng[17:16] != 2'b00;
    end

    task automatic finish_run(input bit timed_out);
        int extra;
        int total;
        extra = others + int'(timed_out);
        if (dual_retires == 0) begin
            $display("no cycle retired two instructions on both ports");
            extra++;
        end
        total = mismatches + extra + UUT.chk_inst.fail_count;
        $display("errors: %0d value mismatches, %0d other, %0d assertion failures",
                 mismatches, extra, UUT.chk_inst.fail_count);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        reset = 1'b1;
        iresp_addr_ok = 1'b0;
        iresp_data = 64'h0;
        rng = 32'd3;
        $readmemh("verif/program_patterns.hex", pat);
        prog_len = int'(pat[0]);
        list_base = prog_len + 1;
        exp_count = int'(pat[list_base]);
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        while (retired < exp_count) @(posedge clk);
        // room for any stray write after the list
        repeat (10) @(posedge clk);
        finish_run(1'b0);
    end

    initial begin
        wait (loaded);
        #((exp_count * 20 + 200) * 8);
        $display("watchdog expired: retire list not completed, %0d of %0d writes seen",
                 retired, exp_count);
        finish_run(1'b1);
    end

endmodule

/* verif/program_patterns.hex */
// program length, program words from 0xbfc00000, retire count,
// then one line per register write: pc wnum wdata
0000001e
3c011234 34025678
2403fffd 24040007
00222821 00833023
00253824 0064402a
00a64825 01295021
24000055 00045821
10830005 0083602a
14830004 240d0001
240e0002 240f0003
24100004 35710100
10000002 24120009
24130009 14000001
0220a021 028ba823
0000b025 02b4b821
1000ffff 00000000
00000011
bfc00000 01 12340000
bfc00004 02 00005678
bfc00008 03 fffffffd
bfc0000c 04 00000007
bfc00010 05 12345678
bfc00014 06 0000000a
bfc00018 07 12340000
bfc0001c 08 00000001
bfc00020 09 1234567a
bfc00024 0a 2468acf4
bfc0002c 0b 00000007
bfc00034 0c 00000000
bfc0004c 11 00000107
bfc00060 14 00000107
bfc00064 15 00000100
bfc00068 16 00000000
bfc0006c 17 00000207

/* dual_mips.f */
rtl/dual_mips_pkg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/issue.sv
rtl/regfile.sv
rtl/execute.sv
rtl/hazard.sv
rtl/dual_mips.sv
verif/dual_mips_chk.sv
verif/retire_monitor.sv
verif/tb_top.sv

/* Makefile */
SIM := obj_dir/Vtb_top
SRCS := $(wildcard rtl/*.sv verif/*.sv)

.PHONY: run clean

run: $(SIM) verif/program_patterns.hex
	@out=$$(./$(SIM) +verilator+error+limit+1000); echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

$(SIM): dual_mips.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_top -f dual_mips.f -o Vtb_top

clean:
	rm -rf obj_dir
